/* include/bundle_macros.svh */
// Bundle lane parameters
`ifndef BUNDLE_MACROS_SVH
`define BUNDLE_MACROS_SVH

// Lane count, lane id must cover every lane
`define NUM_LANES 4
`define LANE_ID_W 2

// Packet and descriptor field widths
`define ADDR_W 32
`define DATA_W 32
`define COUNT_W 16

// Queue depths in packets, powers of two
`define ARBITER_DEPTH 8
`define RESPONSE_DEPTH 4

`endif

/* source/memory_pkg.sv */
// Memory packet types
`include "bundle_macros.svh"

package memory_pkg;

    // Only two operations reach memory
    typedef enum logic {
        cmd_read  = 1'b0,
        cmd_write = 1'b1
    } memory_cmd_t;

    // ------------------------------------------------------------------------
    // Shared request and response packet
    // ------------------------------------------------------------------------
    // 68 bits, valid sits in the top bit
    typedef struct packed {
        logic                  valid;
        // Lane that issued the request, echoed back by memory
        logic [`LANE_ID_W-1:0] lane_id;
        memory_cmd_t           cmd;
        logic [`ADDR_W-1:0]    address;
        // Write data on requests, read data on responses
        logic [`DATA_W-1:0]    data;
    } memory_packet_t;

endpackage : memory_pkg

/* source/lane_pkg.sv */
// Lane control types
`include "bundle_macros.svh"

package lane_pkg;

    // Kernel descriptor, broadcast to every lane
    typedef struct packed {
        logic                valid;
        logic [`ADDR_W-1:0]  base_address;
        logic [`ADDR_W-1:0]  result_address;
        logic [`COUNT_W-1:0] vertex_count;
    } kernel_descriptor_t;

    // Lane FSM states
    typedef enum logic [2:0] {
        lane_idle  = 3'd0,
        lane_read  = 3'd1,
        lane_drain = 3'd2,
        lane_write = 3'd3,
        lane_done  = 3'd4
    } lane_state_t;

endpackage : lane_pkg

/* source/request_arbiter.sv */
// Lane request arbiter
`timescale 1ns/1ps
`include "bundle_macros.svh"

module request_arbiter (
    input  logic                       ap_clk,
    input  logic                       areset,
    input  memory_pkg::memory_packet_t lane_request [`NUM_LANES],
    output logic [`NUM_LANES-1:0]      lane_request_ready,
    output memory_pkg::memory_packet_t request_out,
    input  logic                       request_ready,
    output logic                       queue_empty
);

    import memory_pkg::*;

    localparam int PTR_W = $clog2(`ARBITER_DEPTH);
    localparam logic [PTR_W:0] DEPTH_COUNT = (PTR_W+1)'(`ARBITER_DEPTH);

    memory_packet_t        queue_mem [`ARBITER_DEPTH];
    logic [PTR_W-1:0]      write_ptr;
    logic [PTR_W-1:0]      read_ptr;
    logic [PTR_W:0]        queue_count;
    logic                  queue_full;
    logic                  push;
    logic                  pop;
    logic [`NUM_LANES-1:0] grant;
    logic [`LANE_ID_W-1:0] grant_index;
    logic [`LANE_ID_W-1:0] last_winner;

    assign queue_full  = (queue_count == DEPTH_COUNT);
    assign queue_empty = (queue_count == '0);

    // ------------------------------------------------------------------------
    // Round-robin grant
    // ------------------------------------------------------------------------
    // Search starts one past the last winner and wraps
    always_comb begin
        logic [`LANE_ID_W-1:0] candidate;
        logic                  found;
        grant       = '0;
        grant_index = last_winner;
        found       = 1'b0;
        for (int k = 1; k <= `NUM_LANES; k++) begin
            candidate = last_winner + `LANE_ID_W'(k);
            if (!queue_full && !found && lane_request[candidate].valid) begin
                grant[candidate] = 1'b1;
                grant_index      = candidate;
                found            = 1'b1;
            end
        end
    end

    // Granted lane sees its transfer this cycle
    assign lane_request_ready = grant;
    assign push = |grant;
    assign pop  = !queue_empty && request_ready;

    // Queue head goes straight to the port register
    always_comb begin
        request_out       = queue_mem[read_ptr];
        request_out.valid = !queue_empty;
    end

    // ------------------------------------------------------------------------
    // Circular queue
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            write_ptr   <= '0;
            read_ptr    <= '0;
            queue_count <= '0;
            // Lane 0 wins first
            last_winner <= '1;
        end else begin
            if (push) begin
                write_ptr   <= write_ptr + 1'b1;
                last_winner <= grant_index;
            end
            if (pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   queue_count <= queue_count + 1'b1;
                2'b01:   queue_count <= queue_count - 1'b1;
                default: queue_count <= queue_count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            queue_mem[write_ptr] <= lane_request[grant_index];
        end
    end

    // At most one lane wins per cycle
    assert property (@(posedge ap_clk) disable iff (areset) $onehot0(grant));

    // A push never lands on the unread head entry
    assert property (@(posedge ap_clk) disable iff (areset)
        push |-> (queue_empty || write_ptr != read_ptr));

endmodule : request_arbiter

/* source/response_distributor.sv */
// Memory response distributor
`timescale 1ns/1ps
`include "bundle_macros.svh"

module response_distributor (
    input  logic                       ap_clk,
    input  logic                       areset,
    input  memory_pkg::memory_packet_t response_in,
    output logic                       response_ready,
    output memory_pkg::memory_packet_t lane_response [`NUM_LANES],
    output logic                       queue_empty
);

    import memory_pkg::*;

    localparam int PTR_W = $clog2(`RESPONSE_DEPTH);
    localparam logic [PTR_W:0] ALMOST_FULL = (PTR_W+1)'(`RESPONSE_DEPTH - 1);

    memory_packet_t        queue_mem [`NUM_LANES][`RESPONSE_DEPTH];
    logic [PTR_W-1:0]      write_ptr [`NUM_LANES];
    logic [PTR_W-1:0]      read_ptr [`NUM_LANES];
    logic [PTR_W:0]        queue_count [`NUM_LANES];
    logic [`NUM_LANES-1:0] push;
    logic [`NUM_LANES-1:0] pop;
    logic [`NUM_LANES-1:0] almost_full;

    // Route by lane id, pop whatever is queued
    always_comb begin
        for (int j = 0; j < `NUM_LANES; j++) begin
            push[j]        = response_in.valid && (response_in.lane_id == `LANE_ID_W'(j));
            pop[j]         = (queue_count[j] != '0);
            almost_full[j] = (queue_count[j] >= ALMOST_FULL);
            lane_response[j]       = queue_mem[j][read_ptr[j]];
            lane_response[j].valid = pop[j];
        end
    end

    // Stall memory while any lane is one entry from full
    assign response_ready = ~|almost_full;
    assign queue_empty    = ~|pop;

    // ------------------------------------------------------------------------
    // Per-lane queues
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            for (int j = 0; j < `NUM_LANES; j++) begin
                write_ptr[j]   <= '0;
                read_ptr[j]    <= '0;
                queue_count[j] <= '0;
            end
        end else begin
            for (int j = 0; j < `NUM_LANES; j++) begin
                if (push[j]) begin
                    write_ptr[j] <= write_ptr[j] + 1'b1;
                end
                if (pop[j]) begin
                    read_ptr[j] <= read_ptr[j] + 1'b1;
                end
                case ({push[j], pop[j]})
                    2'b10:   queue_count[j] <= queue_count[j] + 1'b1;
                    2'b01:   queue_count[j] <= queue_count[j] - 1'b1;
                    default: queue_count[j] <= queue_count[j];
                endcase
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int j = 0; j < `NUM_LANES; j++) begin
            if (push[j]) begin
                queue_mem[j][write_ptr[j]] <= response_in;
            end
        end
    end

    // Memory only ever answers reads
    assert property (@(posedge ap_clk) disable iff (areset)
        response_in.valid |-> (response_in.cmd == cmd_read));

endmodule : response_distributor

/* source/lane_engine.sv */
// Graph processing lane
`timescale 1ns/1ps
`include "bundle_macros.svh"

module lane_engine #(
    parameter int LANE_INDEX = 0
) (
    input  logic                         ap_clk,
    input  logic                         areset,
    input  lane_pkg::kernel_descriptor_t descriptor_in,
    output memory_pkg::memory_packet_t   lane_request,
    input  logic                         lane_request_ready,
    input  memory_pkg::memory_packet_t   lane_response,
    output logic                         done_out
);

    import memory_pkg::*;
    import lane_pkg::*;

    lane_state_t         state;
    logic [`ADDR_W-1:0]  read_address;
    logic [`ADDR_W-1:0]  write_address;
    logic [`COUNT_W-1:0] vertex_count;
    logic [`COUNT_W-1:0] issued;
    logic [`COUNT_W-1:0] received;
    logic [`DATA_W-1:0]  sum;
    logic                start;
    logic                request_fire;
    logic                last_read;
    logic                last_response;

    // A new kernel is taken only when the lane rests
    assign start = descriptor_in.valid && (state == lane_idle || state == lane_done);
    assign request_fire  = lane_request.valid && lane_request_ready;
    assign last_read     = (issued == vertex_count - `COUNT_W'(1));
    assign last_response = lane_response.valid && (received == vertex_count - `COUNT_W'(1));
    assign done_out      = (state == lane_idle) || (state == lane_done);

    // ------------------------------------------------------------------------
    // Lane FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state    <= lane_idle;
            issued   <= '0;
            received <= '0;
            sum      <= '0;
        end else begin
            case (state)
                lane_idle, lane_done: begin
                    if (start) begin
                        issued   <= '0;
                        received <= '0;
                        sum      <= '0;
                        // Empty slice writes a zero sum right away
                        state <= (descriptor_in.vertex_count == '0) ? lane_write : lane_read;
                    end
                end
                lane_read: begin
                    if (request_fire) begin
                        issued <= issued + 1'b1;
                        if (last_read) begin
                            state <= lane_drain;
                        end
                    end
                end
                lane_drain: begin
                    if (last_response) begin
                        state <= lane_write;
                    end
                end
                lane_write: begin
                    if (request_fire) begin
                        state <= lane_done;
                    end
                end
                default: state <= lane_idle;
            endcase
            // Responses overlap the reads, so sum in read and drain alike
            if (lane_response.valid) begin
                received <= received + 1'b1;
                sum      <= sum + lane_response.data;
            end
        end
    end

    // Slice start is base plus lane index times count
    always_ff @(posedge ap_clk) begin
        if (start) begin
            vertex_count  <= descriptor_in.vertex_count;
            write_address <= descriptor_in.result_address + `ADDR_W'(LANE_INDEX);
            read_address  <= descriptor_in.base_address
                           + `ADDR_W'(LANE_INDEX) * `ADDR_W'(descriptor_in.vertex_count);
        end else if (state == lane_read && request_fire) begin
            read_address <= read_address + 1'b1;
        end
    end

    // Request built from registers only, stable until taken
    always_comb begin
        lane_request.valid   = (state == lane_read) || (state == lane_write);
        lane_request.lane_id = `LANE_ID_W'(LANE_INDEX);
        lane_request.cmd     = (state == lane_write) ? cmd_write : cmd_read;
        lane_request.address = (state == lane_write) ? write_address : read_address;
        lane_request.data    = (state == lane_write) ? sum : '0;
    end

    // Distributor never routes a stray response to an idle lane
    assert property (@(posedge ap_clk) disable iff (areset)
        (state == lane_idle) |-> !lane_response.valid);

endmodule : lane_engine

/* source/bundle_lanes.sv */
// Lane bundle top level
`timescale 1ns/1ps
`include "bundle_macros.svh"

module bundle_lanes (
    input  logic                         ap_clk,
    input  logic                         areset_lanes,
    input  lane_pkg::kernel_descriptor_t descriptor_in,
    output memory_pkg::memory_packet_t   request_out,
    input  logic                         request_ready,
    input  memory_pkg::memory_packet_t   response_in,
    output logic                         response_ready,
    output logic                         done_out
);

    import memory_pkg::*;
    import lane_pkg::*;

    logic                  reset_top;
    logic                  reset_arbiter;
    logic                  reset_distributor;
    logic                  reset_lane [`NUM_LANES];
    kernel_descriptor_t    descriptor_reg;
    kernel_descriptor_t    descriptor_lane [`NUM_LANES];
    logic                  descriptor_seen;
    memory_packet_t        response_reg;
    memory_packet_t        arbiter_out;
    logic                  arbiter_ready;
    logic                  arbiter_empty;
    logic                  distributor_empty;
    memory_packet_t        lane_request [`NUM_LANES];
    logic [`NUM_LANES-1:0] lane_request_ready;
    memory_packet_t        lane_response [`NUM_LANES];
    logic [`NUM_LANES-1:0] lane_done;

    // ------------------------------------------------------------------------
    // Reset fan-out and descriptor broadcast
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        reset_top         <= areset_lanes;
        reset_arbiter     <= areset_lanes;
        reset_distributor <= areset_lanes;
        for (int j = 0; j < `NUM_LANES; j++) begin
            reset_lane[j] <= areset_lanes;
        end
    end

    // Port stage then one copy per lane, two cycles in all
    always_ff @(posedge ap_clk) begin
        descriptor_reg <= descriptor_in;
        for (int j = 0; j < `NUM_LANES; j++) begin
            descriptor_lane[j] <= descriptor_reg;
        end
        if (reset_top) begin
            descriptor_reg.valid <= 1'b0;
            for (int j = 0; j < `NUM_LANES; j++) begin
                descriptor_lane[j].valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Memory port registers
    // ------------------------------------------------------------------------
    // Output stage refills when empty or drained this cycle
    assign arbiter_ready = !request_out.valid || request_ready;

    always_ff @(posedge ap_clk) begin
        if (arbiter_ready) begin
            request_out <= arbiter_out;
        end
        response_reg       <= response_in;
        response_reg.valid <= response_in.valid && response_ready;
        if (reset_top) begin
            request_out.valid  <= 1'b0;
            response_reg.valid <= 1'b0;
        end
    end

    // Done waits for a kernel, all lanes, and empty queues and stages
    always_ff @(posedge ap_clk) begin
        if (reset_top) begin
            descriptor_seen <= 1'b0;
            done_out        <= 1'b0;
        end else begin
            descriptor_seen <= descriptor_seen || descriptor_reg.valid;
            done_out <= descriptor_seen && (&lane_done) && arbiter_empty
                     && distributor_empty && !request_out.valid && !response_reg.valid
                     && !descriptor_in.valid && !descriptor_reg.valid
                     && !descriptor_lane[0].valid;
        end
    end

    // ------------------------------------------------------------------------
    // Arbiter, distributor and lanes
    // ------------------------------------------------------------------------
    request_arbiter i_request_arbiter (
        .ap_clk             (ap_clk),
        .areset             (reset_arbiter),
        .lane_request       (lane_request),
        .lane_request_ready (lane_request_ready),
        .request_out        (arbiter_out),
        .request_ready      (arbiter_ready),
        .queue_empty        (arbiter_empty)
    );

    response_distributor i_response_distributor (
        .ap_clk         (ap_clk),
        .areset         (reset_distributor),
        .response_in    (response_reg),
        .response_ready (response_ready),
        .lane_response  (lane_response),
        .queue_empty    (distributor_empty)
    );

    for (genvar j = 0; j < `NUM_LANES; j++) begin : generate_lane
        lane_engine #(
            .LANE_INDEX(j)
        ) i_lane_engine (
            .ap_clk             (ap_clk),
            .areset             (reset_lane[j]),
            .descriptor_in      (descriptor_lane[j]),
            .lane_request       (lane_request[j]),
            .lane_request_ready (lane_request_ready[j]),
            .lane_response      (lane_response[j]),
            .done_out           (lane_done[j])
        );
    end

endmodule : bundle_lanes

/* bench/bundle_lanes_tb.sv */
// Lane bundle testbench
`timescale 1ns/1ps
`include "bundle_macros.svh"

module bundle_lanes_tb;

    import memory_pkg::*;
    import lane_pkg::*;

    localparam int MEM_WORDS = 256;

    logic                ap_clk = 1'b0;
    logic                areset_lanes = 1'b1;
    kernel_descriptor_t  descriptor_in;
    memory_packet_t      request_out;
    logic                request_ready;
    memory_packet_t      response_in;
    logic                response_ready;
    logic                done_out;

    // Memory model, read scoreboard and current kernel
    logic [`DATA_W-1:0]  mem [MEM_WORDS];
    bit                  read_seen [MEM_WORDS];
    bit                  write_seen [`NUM_LANES];
    memory_packet_t      pending [$];
    logic                response_taken = 1'b0;
    int                  response_delay = 0;
    int                  reads_seen;
    int                  writes_seen;
    logic [31:0]         lfsr_state = 32'h499c;
    logic [`ADDR_W-1:0]  kernel_base;
    logic [`ADDR_W-1:0]  kernel_result;
    logic [`COUNT_W-1:0] kernel_count;

    bundle_lanes i_dut (
        .ap_clk         (ap_clk),
        .areset_lanes   (areset_lanes),
        .descriptor_in  (descriptor_in),
        .request_out    (request_out),
        .request_ready  (request_ready),
        .response_in    (response_in),
        .response_ready (response_ready),
        .done_out       (done_out)
    );

    always #20 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Random bits, reference model and compare tasks
    // ------------------------------------------------------------------------
    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Slice sum of one lane, wraps at DATA_W bits
    function automatic logic [`DATA_W-1:0] reference_sum(input int lane);
        logic [`DATA_W-1:0] total;
        int                 first;
        total = '0;
        first = int'(kernel_base) + lane * int'(kernel_count);
        for (int i = 0; i < int'(kernel_count); i++) begin
            total = total + mem[first + i];
        end
        return total;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_packet(input memory_packet_t actual, input memory_packet_t expected,
                                input string what);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t ns: %s got %h expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t ns: %s got %b expected %b",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_sum(input logic [`DATA_W-1:0] actual,
                             input logic [`DATA_W-1:0] expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t ns: %s got %h expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // Memory port monitor
    // ------------------------------------------------------------------------
    // Transfers sampled on the rising edge, before the DUT registers move
    always @(posedge ap_clk) begin : watch_memory_port
        memory_packet_t     expected;
        memory_packet_t     response;
        logic [`ADDR_W-1:0] offset;
        int                 lane;
        if (!areset_lanes && request_out.valid && request_ready) begin
            expected = request_out;
            if (request_out.cmd == cmd_read) begin
                offset = request_out.address - kernel_base;
                if (request_out.address >= MEM_WORDS
                    || offset >= `ADDR_W'(`NUM_LANES) * `ADDR_W'(kernel_count)) begin
                    report_failure($sformatf("Fail at %0t ns: read of %h outside every slice",
                                             $time, request_out.address));
                end
                if (read_seen[int'(request_out.address)]) begin
                    report_failure($sformatf("Fail at %0t ns: address %h read twice",
                                             $time, request_out.address));
                end
                lane = int'(offset / `ADDR_W'(kernel_count));
                expected.lane_id = `LANE_ID_W'(lane);
                expected.data    = '0;
                check_packet(request_out, expected, "read request");
                read_seen[int'(request_out.address)] = 1'b1;
                reads_seen++;
                // Memory echoes the request with its data word
                response      = request_out;
                response.data = mem[int'(request_out.address)];
                pending.push_back(response);
            end else begin
                offset = request_out.address - kernel_result;
                if (offset >= `NUM_LANES || write_seen[int'(offset[1:0])]) begin
                    report_failure($sformatf("Fail at %0t ns: unexpected write to %h",
                                             $time, request_out.address));
                end
                lane = int'(offset);
                expected.lane_id = `LANE_ID_W'(lane);
                check_packet(request_out, expected, "result write");
                check_sum(request_out.data, reference_sum(lane), "result write data");
                mem[int'(request_out.address)] = request_out.data;
                write_seen[lane] = 1'b1;
                writes_seen++;
            end
        end
        if (!areset_lanes && response_in.valid && response_ready) begin
            response_taken = 1'b1;
        end
    end

    // Ready three cycles in four, responses held until taken
    always @(negedge ap_clk) begin : drive_memory
        request_ready = (random_bits(2) != '0);
        if (response_taken || !response_in.valid) begin
            response_taken = 1'b0;
            response_in    = '0;
            if (response_delay > 0) begin
                response_delay--;
            end else if (pending.size() > 0) begin
                response_in    = pending.pop_front();
                response_delay = int'(random_bits(2));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Kernel runs
    // ------------------------------------------------------------------------
    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done_out !== 1'b1) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles > 4000) begin
                report_failure("Timed out waiting for done_out to rise");
            end
        end
    endtask

    task automatic run_kernel(input logic [`ADDR_W-1:0] base, input logic [`ADDR_W-1:0] result,
                              input logic [`COUNT_W-1:0] count);
        kernel_base   = base;
        kernel_result = result;
        kernel_count  = count;
        reads_seen    = 0;
        writes_seen   = 0;
        foreach (read_seen[i]) begin
            read_seen[i] = 1'b0;
        end
        foreach (write_seen[j]) begin
            write_seen[j] = 1'b0;
        end
        @(negedge ap_clk);
        descriptor_in = '{valid: 1'b1, base_address: base, result_address: result,
                          vertex_count: count};
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
        // Done drops on the edge that takes the descriptor
        check_done(done_out, 1'b0, "done_out after new descriptor");
        wait_for_done();
        if (writes_seen != `NUM_LANES || reads_seen != `NUM_LANES * int'(count)) begin
            report_failure($sformatf("Fail at %0t ns: done with %0d reads and %0d writes",
                                     $time, reads_seen, writes_seen));
        end
    endtask

    initial begin : run_tests
        descriptor_in = '0;
        request_ready = 1'b0;
        response_in   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = random_bits(`DATA_W);
        end
        repeat (16) @(negedge ap_clk);
        areset_lanes = 1'b0;
        // Quiet port while no kernel has started
        repeat (20) begin
            @(negedge ap_clk);
            check_done(done_out, 1'b0, "done_out after reset");
            check_done(request_out.valid, 1'b0, "request_out.valid after reset");
            check_done(response_ready, 1'b1, "response_ready after reset");
        end
        run_kernel(32'd16, 32'd200, 16'd6);
        // Second descriptor, empty slices then a longer slice
        run_kernel(32'd64, 32'd208, 16'd0);
        run_kernel(32'd64, 32'd216, 16'd9);
        $display("TESTS PASSED");
        $finish;
    end

endmodule : bundle_lanes_tb

/* bundle_lanes.f */
+incdir+include
source/memory_pkg.sv
source/lane_pkg.sv
source/request_arbiter.sv
source/response_distributor.sv
source/lane_engine.sv
source/bundle_lanes.sv
bench/bundle_lanes_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the lane bundle simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=bundle_lanes_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module bundle_lanes_tb \
    -f bundle_lanes.f \
    -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./"$BUILD_DIR"/"$SIM" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
